/* rtl/wm_pkg.sv */
////////////////////////////////////////
// Shared definitions for the AXI4 write master
// Bus widths, AXI burst limits, derived burst constants
// Packed structs for command, burst plan and channel payloads
////////////////////////////////////////

package wm_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////
  localparam int ADDR_W         = 32;
  localparam int DATA_W         = 32;
  localparam int DATA_BYTES     = DATA_W / 8;
  localparam int LOG_DATA_BYTES = $clog2(DATA_BYTES);

  ////////////////////////////////////////
  // Burst limits
  ////////////////////////////////////////
  // Protocol limits for INCR bursts
  localparam int AXI_MAX_BEATS   = 256;
  localparam int AXI_MAX_BYTES   = 4096;
  // Full burst is bounded by both the beat and the 4 KB limit
  localparam int BURST_BEATS     = (AXI_MAX_BYTES / DATA_BYTES < AXI_MAX_BEATS) ?
                                   AXI_MAX_BYTES / DATA_BYTES : AXI_MAX_BEATS;
  localparam int LOG_BURST_BEATS = $clog2(BURST_BEATS);
  // Address stride between consecutive bursts
  localparam int BURST_BYTES     = BURST_BEATS * DATA_BYTES;
  // Width of a burst count
  localparam int TXN_W           = ADDR_W - LOG_DATA_BYTES - LOG_BURST_BEATS;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] size;
  } xfer_cmd_t;

  typedef struct packed {
    logic [TXN_W-1:0]      num_bursts;  // Bursts minus one
    logic [7:0]            last_len;    // Final burst length minus one
    logic [DATA_BYTES-1:0] final_strb;
    logic                  single;
  } burst_plan_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
  } aw_req_t;

  typedef struct packed {
    logic [DATA_W-1:0]     data;
    logic [DATA_BYTES-1:0] strb;
    logic                  last;
  } w_beat_t;

endpackage

/* rtl/xfer_setup.sv */
////////////////////////////////////////
// Command register and burst planner
// Aligns the start address, sizes the transfer in beats
// and bursts, builds the final strobe, issues start
////////////////////////////////////////

module xfer_setup (
  input  logic                       aclk,
  input  logic                       areset,
  input  logic                       ctrl_start,
  input  wm_pkg::xfer_cmd_t          ctrl_cmd,
  output logic                       start,
  output wm_pkg::burst_plan_t        plan,
  output logic [wm_pkg::ADDR_W-1:0]  base_addr
);

  localparam int LOG_B = wm_pkg::LOG_DATA_BYTES;
  localparam int TOT_W = wm_pkg::ADDR_W - LOG_B;
  // Low address bits cleared to reach a burst boundary
  localparam logic [wm_pkg::ADDR_W-1:0] ADDR_MASK = wm_pkg::ADDR_W'(wm_pkg::BURST_BYTES - 1);

  logic                      ctrl_start_d1;
  logic [TOT_W-1:0]          total_len_r;  // Beats minus one
  logic [LOG_B-1:0]          byte_rem_r;   // Valid bytes in final beat minus one
  logic [TOT_W-1:0]          size_beats;
  logic                      size_partial;
  logic [wm_pkg::ADDR_W-1:0] plan_addr_r;

  assign size_beats   = ctrl_cmd.size[wm_pkg::ADDR_W-1:LOG_B];
  assign size_partial = |ctrl_cmd.size[LOG_B-1:0];
  assign base_addr    = plan_addr_r;

  // Capture the command
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      plan_addr_r <= ctrl_cmd.addr & ~ADDR_MASK;
      // Round up to whole beats, kept as count minus one
      total_len_r <= size_partial ? size_beats : size_beats - 1'b1;
      byte_rem_r  <= ctrl_cmd.size[LOG_B-1:0] - 1'b1;
    end
  end

  // Start comes two cycles after the command edge
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_start_d1 <= 1'b0;
      start         <= 1'b0;
    end else begin
      ctrl_start_d1 <= ctrl_start;
      start         <= ctrl_start_d1;
    end
  end

  ////////////////////////////////////////
  // Burst plan
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (ctrl_start_d1) begin
      plan.num_bursts <= total_len_r[wm_pkg::LOG_BURST_BEATS +: wm_pkg::TXN_W];
      plan.last_len   <= total_len_r[0 +: wm_pkg::LOG_BURST_BEATS];
      plan.single     <= total_len_r[wm_pkg::LOG_BURST_BEATS +: wm_pkg::TXN_W] == '0;
      // Byte lanes up to the remainder are enabled
      for (int i = 0; i < wm_pkg::DATA_BYTES; i++) begin
        plan.final_strb[i] <= (i <= int'(byte_rem_r));
      end
    end
  end

endmodule

/* rtl/stream_fifo.sv */
////////////////////////////////////////
// Synchronous first-word-fall-through FIFO
// Register array plus a registered output stage
////////////////////////////////////////

module stream_fifo #(
  parameter int FIFO_DEPTH = 32
) (
  input  logic                       aclk,
  input  logic                       areset,
  input  logic                       s_axis_tvalid,
  input  logic [wm_pkg::DATA_W-1:0]  s_axis_tdata,
  input  logic                       fifo_pop,
  output logic                       s_axis_tready,
  output logic                       fifo_valid,
  output logic [wm_pkg::DATA_W-1:0]  fifo_data
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  logic [wm_pkg::DATA_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic [CNT_W-1:0]          count;  // Entries incl. the output stage
  logic                      push;
  logic                      pop;
  logic                      out_free;
  logic                      mem_empty;
  logic                      bypass;

  assign s_axis_tready = count != CNT_W'(FIFO_DEPTH);
  assign push          = s_axis_tvalid & s_axis_tready;
  assign pop           = fifo_pop & fifo_valid;
  // Output stage can take a word this cycle
  assign out_free      = ~fifo_valid | pop;
  assign mem_empty     = count == CNT_W'(fifo_valid);
  // Incoming word goes straight to the output stage
  assign bypass        = out_free & mem_empty & push;

  always_ff @(posedge aclk) begin
    if (areset) begin
      count      <= '0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_valid <= 1'b0;
    end else begin
      count <= count + CNT_W'(push) - CNT_W'(pop);
      if (push & ~bypass) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (out_free) begin
        if (!mem_empty) begin
          rd_ptr     <= rd_ptr + 1'b1;
          fifo_valid <= 1'b1;
        end else begin
          fifo_valid <= push;
        end
      end
    end
  end

  // Storage and output data
  always_ff @(posedge aclk) begin
    if (push & ~bypass) begin
      mem[wr_ptr] <= s_axis_tdata;
    end
    if (out_free) begin
      fifo_data <= mem_empty ? s_axis_tdata : mem[rd_ptr];
    end
  end

endmodule

/* rtl/wdata_channel.sv */
////////////////////////////////////////
// AXI write data channel engine
// Running gate, beat and burst counters, last and strobe,
// first-beat pulse for the address channel
////////////////////////////////////////

module wdata_channel (
  input  logic                       aclk,
  input  logic                       areset,
  input  logic                       start,
  input  wm_pkg::burst_plan_t        plan,
  input  logic                       fifo_valid,
  input  logic [wm_pkg::DATA_W-1:0]  fifo_data,
  input  logic                       m_axi_wready,
  output logic                       fifo_pop,
  output logic                       m_axi_wvalid,
  output wm_pkg::w_beat_t            m_axi_w,
  output logic                       first_beat
);

  logic                     running;
  logic                     wxfer;
  logic                     last;
  logic                     final_burst;
  logic                     almost_final;
  logic                     final_xfer;
  logic [7:0]               beat_cnt;    // Beats left in burst minus one
  logic [wm_pkg::TXN_W-1:0] burst_left;  // Bursts left after this one
  logic                     wfirst;
  logic                     first_d1;

  // Beats only flow once the transfer size is known
  assign m_axi_wvalid = fifo_valid & running;
  assign fifo_pop     = m_axi_wready & running;
  assign wxfer        = m_axi_wvalid & m_axi_wready;

  assign last         = beat_cnt == '0;
  assign final_burst  = burst_left == '0;
  assign almost_final = burst_left == wm_pkg::TXN_W'(1);
  assign final_xfer   = wxfer & last & final_burst;

  always_comb begin
    m_axi_w.data = fifo_data;
    // Partial strobe only on the very last beat
    m_axi_w.strb = (last & final_burst) ? plan.final_strb : '1;
    m_axi_w.last = last;
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      running <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
    end else if (final_xfer) begin
      running <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Beat and burst counters
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      beat_cnt <= 8'(wm_pkg::BURST_BEATS - 1);
    end else if (start) begin
      beat_cnt <= plan.single ? plan.last_len : 8'(wm_pkg::BURST_BEATS - 1);
    end else if (wxfer & last & almost_final) begin
      // Entering the final, possibly short, burst
      beat_cnt <= plan.last_len;
    end else if (wxfer) begin
      beat_cnt <= last ? 8'(wm_pkg::BURST_BEATS - 1) : beat_cnt - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      burst_left <= '0;
    end else if (start) begin
      burst_left <= plan.num_bursts;
    end else if (wxfer & last & ~final_burst) begin
      burst_left <= burst_left - 1'b1;
    end
  end

  ////////////////////////////////////////
  // First beat detection
  ////////////////////////////////////////
  // Next beat after a last starts a new burst
  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst     <= 1'b1;
      first_d1   <= 1'b0;
      first_beat <= 1'b0;
    end else begin
      if (wxfer) begin
        wfirst <= last;
      end
      first_d1   <= m_axi_wvalid & wfirst;
      // Rising edge of a waiting first beat
      first_beat <= m_axi_wvalid & wfirst & ~first_d1;
    end
  end

endmodule

/* rtl/waddr_channel.sv */
////////////////////////////////////////
// AXI write address channel engine
// Issues one address per burst once its first beat waits
////////////////////////////////////////

module waddr_channel (
  input  logic                       aclk,
  input  logic                       areset,
  input  logic                       start,
  input  wm_pkg::burst_plan_t        plan,
  input  logic [wm_pkg::ADDR_W-1:0]  base_addr,
  input  logic                       first_beat,
  input  logic                       aw_stall,
  input  logic                       m_axi_awready,
  output logic                       m_axi_awvalid,
  output wm_pkg::aw_req_t            m_axi_aw,
  output logic                       aw_accept
);

  logic [7:0]                pend_cnt;  // First beats still lacking an address
  logic                      idle;
  logic [wm_pkg::ADDR_W-1:0] addr;
  logic [wm_pkg::TXN_W-1:0]  aw_left;
  logic                      aw_final;

  assign aw_accept = m_axi_awvalid & m_axi_awready;
  assign idle      = pend_cnt == '0;
  assign aw_final  = aw_left == '0;

  always_comb begin
    m_axi_aw.addr = addr;
    // Short length only on the last burst
    m_axi_aw.len  = aw_final ? plan.last_len : 8'(wm_pkg::BURST_BEATS - 1);
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      pend_cnt <= '0;
    end else begin
      pend_cnt <= pend_cnt + 8'(first_beat) - 8'(aw_accept);
    end
  end

  ////////////////////////////////////////
  // Valid and address
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_awvalid <= 1'b0;
    end else if (~idle & ~m_axi_awvalid & ~aw_stall) begin
      m_axi_awvalid <= 1'b1;
    end else if (m_axi_awready) begin
      m_axi_awvalid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (start) begin
      addr <= base_addr;
    end else if (aw_accept) begin
      addr <= addr + wm_pkg::ADDR_W'(wm_pkg::BURST_BYTES);
    end
  end

  // Bursts still to address after the current one
  always_ff @(posedge aclk) begin
    if (areset) begin
      aw_left <= '0;
    end else if (start) begin
      aw_left <= plan.num_bursts;
    end else if (aw_accept & ~aw_final) begin
      aw_left <= aw_left - 1'b1;
    end
  end

endmodule

/* rtl/wresp_tracker.sv */
////////////////////////////////////////
// Write response tracker
// Outstanding-burst limit and done pulse
////////////////////////////////////////

module wresp_tracker #(
  parameter int MAX_OUTSTANDING = 32
) (
  input  logic                 aclk,
  input  logic                 areset,
  input  logic                 start,
  input  wm_pkg::burst_plan_t  plan,
  input  logic                 aw_accept,
  input  logic                 m_axi_bvalid,
  output logic                 aw_stall,
  output logic                 ctrl_done
);

  localparam int OUT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [OUT_W-1:0]         out_cnt;    // Accepted but unanswered bursts
  logic [wm_pkg::TXN_W-1:0] resp_left;  // Responses after the next one

  // Hold new addresses at the limit
  assign aw_stall = out_cnt == OUT_W'(MAX_OUTSTANDING);

  always_ff @(posedge aclk) begin
    if (areset) begin
      out_cnt <= '0;
    end else begin
      out_cnt <= out_cnt + OUT_W'(aw_accept) - OUT_W'(m_axi_bvalid);
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      resp_left <= '0;
      ctrl_done <= 1'b0;
    end else begin
      if (start) begin
        resp_left <= plan.num_bursts;
      end else if (m_axi_bvalid) begin
        resp_left <= resp_left - 1'b1;
      end
      // Final response ends the command
      ctrl_done <= m_axi_bvalid & (resp_left == '0);
    end
  end

endmodule

/* rtl/axi_write_master.sv */
////////////////////////////////////////
// AXI4 write master top level
// Setup, stream FIFO and the three channel engines
////////////////////////////////////////

module axi_write_master #(
  parameter int MAX_OUTSTANDING = 32,
  parameter int FIFO_DEPTH      = 32
) (
  input  logic                       aclk,
  input  logic                       areset,
  // Command and completion
  input  logic                       ctrl_start,
  input  wm_pkg::xfer_cmd_t          ctrl_cmd,
  output logic                       ctrl_done,
  // Stream input
  input  logic                       s_axis_tvalid,
  output logic                       s_axis_tready,
  input  logic [wm_pkg::DATA_W-1:0]  s_axis_tdata,
  // Write address
  output logic                       m_axi_awvalid,
  input  logic                       m_axi_awready,
  output wm_pkg::aw_req_t            m_axi_aw,
  // Write data
  output logic                       m_axi_wvalid,
  input  logic                       m_axi_wready,
  output wm_pkg::w_beat_t            m_axi_w,
  // Write response, always ready
  input  logic                       m_axi_bvalid
);

  logic                      start;
  wm_pkg::burst_plan_t       plan;
  logic [wm_pkg::ADDR_W-1:0] base_addr;
  logic                      fifo_valid;
  logic [wm_pkg::DATA_W-1:0] fifo_data;
  logic                      fifo_pop;
  logic                      first_beat;
  logic                      aw_accept;
  logic                      aw_stall;

  xfer_setup u_setup (
    .aclk       (aclk),
    .areset     (areset),
    .ctrl_start (ctrl_start),
    .ctrl_cmd   (ctrl_cmd),
    .start      (start),
    .plan       (plan),
    .base_addr  (base_addr)
  );

  stream_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .aclk          (aclk),
    .areset        (areset),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tdata  (s_axis_tdata),
    .fifo_pop      (fifo_pop),
    .s_axis_tready (s_axis_tready),
    .fifo_valid    (fifo_valid),
    .fifo_data     (fifo_data)
  );

  wdata_channel u_wdata (
    .aclk         (aclk),
    .areset       (areset),
    .start        (start),
    .plan         (plan),
    .fifo_valid   (fifo_valid),
    .fifo_data    (fifo_data),
    .m_axi_wready (m_axi_wready),
    .fifo_pop     (fifo_pop),
    .m_axi_wvalid (m_axi_wvalid),
    .m_axi_w      (m_axi_w),
    .first_beat   (first_beat)
  );

  waddr_channel u_waddr (
    .aclk          (aclk),
    .areset        (areset),
    .start         (start),
    .plan          (plan),
    .base_addr     (base_addr),
    .first_beat    (first_beat),
    .aw_stall      (aw_stall),
    .m_axi_awready (m_axi_awready),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_aw      (m_axi_aw),
    .aw_accept     (aw_accept)
  );

  wresp_tracker #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_wresp (
    .aclk         (aclk),
    .areset       (areset),
    .start        (start),
    .plan         (plan),
    .aw_accept    (aw_accept),
    .m_axi_bvalid (m_axi_bvalid),
    .aw_stall     (aw_stall),
    .ctrl_done    (ctrl_done)
  );

endmodule

/* tb/axi_write_master_assertions.sv */
////////////////////////////////////////
// Concurrent AXI protocol checks for the write master
// Channel stability, done pulse width, outstanding limit
////////////////////////////////////////

module axi_write_master_assertions #(
  parameter int MAX_OUTSTANDING = 32
) (
  input logic             aclk,
  input logic             areset,
  input logic             m_axi_awvalid,
  input logic             m_axi_awready,
  input wm_pkg::aw_req_t  m_axi_aw,
  input logic             m_axi_wvalid,
  input logic             m_axi_wready,
  input wm_pkg::w_beat_t  m_axi_w,
  input logic             m_axi_bvalid,
  input logic             ctrl_done
);

  // Accepted addresses still waiting for a response
  logic [7:0] unanswered;

  always_ff @(posedge aclk) begin
    if (areset) begin
      unanswered <= '0;
    end else begin
      unanswered <= unanswered + 8'(m_axi_awvalid & m_axi_awready) - 8'(m_axi_bvalid);
    end
  end

  // Address and its payload held until awready
  aw_stable: assert property (@(posedge aclk) disable iff (areset)
    m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_aw))
    else $error("aw channel changed before awready");

  // Data beat held until wready
  w_stable: assert property (@(posedge aclk) disable iff (areset)
    m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_w))
    else $error("w channel changed before wready");

  done_single: assert property (@(posedge aclk) disable iff (areset)
    ctrl_done |=> !ctrl_done)
    else $error("ctrl_done high for two cycles");

  // No address accepted at the limit
  out_limit: assert property (@(posedge aclk) disable iff (areset)
    int'(unanswered) >= MAX_OUTSTANDING |-> !(m_axi_awvalid && m_axi_awready))
    else $error("address accepted with too many bursts unanswered");

endmodule

bind axi_write_master axi_write_master_assertions #(
  .MAX_OUTSTANDING (MAX_OUTSTANDING)
) u_assertions (
  .aclk          (aclk),
  .areset        (areset),
  .m_axi_awvalid (m_axi_awvalid),
  .m_axi_awready (m_axi_awready),
  .m_axi_aw      (m_axi_aw),
  .m_axi_wvalid  (m_axi_wvalid),
  .m_axi_wready  (m_axi_wready),
  .m_axi_w       (m_axi_w),
  .m_axi_bvalid  (m_axi_bvalid),
  .ctrl_done     (ctrl_done)
);

/* tb/tb_axi_write_master.sv */
////////////////////////////////////////
// Testbench for the AXI4 write master
// Stream driver, memory-side slave model, reference model,
// compare process and timeout
////////////////////////////////////////

module tb_axi_write_master;

  localparam int          MAX_OUT    = 4;
  localparam int          FIFO_WORDS = 32;
  localparam int          NUM_TESTS  = 10;
  localparam logic [31:0] WORD_BASE  = 32'h5a00_0000;

  logic            aclk = 1'b0;
  logic            areset;
  logic            ctrl_start;
  wm_pkg::xfer_cmd_t ctrl_cmd;
  logic            ctrl_done;
  logic            s_axis_tvalid;
  logic            s_axis_tready;
  logic [31:0]     s_axis_tdata;
  logic            m_axi_awvalid;
  logic            m_axi_awready;
  wm_pkg::aw_req_t m_axi_aw;
  logic            m_axi_wvalid;
  logic            m_axi_wready;
  wm_pkg::w_beat_t m_axi_w;
  logic            m_axi_bvalid;

  // Command list, the last one runs with responses withheld
  string       test_names [NUM_TESTS] = '{"burst_split", "data_order", "strobe_4097",
                                          "strobe_4098", "strobe_4099", "alignment",
                                          "b2b_1byte", "b2b_1beat", "b2b_257beats",
                                          "outstanding"};
  logic [31:0] test_addr [NUM_TESTS] = '{32'h0001_0000, 32'h0002_0000, 32'h0003_0000,
                                         32'h0004_0400, 32'h0005_0800, 32'h0006_0345,
                                         32'h0007_0000, 32'h0007_0400, 32'h0007_0800,
                                         32'h0010_0000};
  logic [31:0] test_size [NUM_TESTS] = '{32'd5000, 32'd2600, 32'd4097, 32'd4098,
                                         32'd4099, 32'd700, 32'd1, 32'd4, 32'd1028,
                                         32'd10240};

  integer          seed = 32'h8c84;
  string           test_name = "reset";
  wm_pkg::aw_req_t exp_aw_q [$];
  wm_pkg::w_beat_t exp_w_q [$];
  int exp_word     = 0;
  int stream_total = 0;
  int stream_idx   = 0;
  bit stream_took  = 1'b0;
  bit hold_resp    = 1'b0;
  int aw_total     = 0;
  int wlast_total  = 0;
  int beat_total   = 0;
  int resp_issued  = 0;
  int resp_wait    = 0;
  int cmd_bursts   = 0;
  int cmd_resp     = 0;
  int cmd_aw       = 0;
  int cmd_beats    = 0;
  int done_count   = 0;
  int checks       = 0;
  int errors       = 0;
  int cycles       = 0;
  int cycle_limit  = 0;

  axi_write_master #(
    .MAX_OUTSTANDING (MAX_OUT),
    .FIFO_DEPTH      (FIFO_WORDS)
  ) u_axi_write_master (
    .aclk          (aclk),
    .areset        (areset),
    .ctrl_start    (ctrl_start),
    .ctrl_cmd      (ctrl_cmd),
    .ctrl_done     (ctrl_done),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_aw      (m_axi_aw),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_w       (m_axi_w),
    .m_axi_bvalid  (m_axi_bvalid)
  );

  always #2 aclk = ~aclk;

  ////////////////////////////////////////
  // Reference model and compare tasks
  ////////////////////////////////////////
  // Queues the addresses and beats of one command, returns its burst count
  function automatic int expected_transfer(input wm_pkg::xfer_cmd_t cmd);
    int              beats;
    int              bursts;
    int              len;
    logic [31:0]     base;
    wm_pkg::aw_req_t aw;
    wm_pkg::w_beat_t w;
    beats  = int'((cmd.size + 32'd3) >> 2);
    bursts = (beats + 255) / 256;
    // Bursts start on a 1 KB boundary
    base   = cmd.addr & ~32'h3ff;
    for (int b = 0; b < bursts; b++) begin
      len     = (b == bursts - 1) ? beats - 256 * b : 256;
      aw.addr = base + 32'(b * 1024);
      aw.len  = 8'(len - 1);
      exp_aw_q.push_back(aw);
      for (int i = 0; i < len; i++) begin
        w.data = WORD_BASE + 32'(exp_word);
        w.last = (i == len - 1);
        w.strb = 4'hf;
        // Partial bytes only in the very last beat
        if (b == bursts - 1 && i == len - 1 && cmd.size[1:0] != 2'b00) begin
          w.strb = 4'((32'd1 << cmd.size[1:0]) - 32'd1);
        end
        exp_w_q.push_back(w);
        exp_word++;
      end
    end
    return bursts;
  endfunction

  task automatic check_aw(input string name, input wm_pkg::aw_req_t exp,
                          input wm_pkg::aw_req_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s aw: expected addr=%h len=%0d, actual addr=%h len=%0d",
               name, exp.addr, exp.len, got.addr, got.len);
    end
  endtask

  task automatic check_w(input string name, input wm_pkg::w_beat_t exp,
                         input wm_pkg::w_beat_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s w: expected data=%h strb=%b last=%b, actual data=%h strb=%b last=%b",
               name, exp.data, exp.strb, exp.last, got.data, got.strb, got.last);
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s tready: expected %b, actual %b", name, exp, got);
    end
  endtask

  task automatic check_done(input string name, input int exp, input int got);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAIL %s done: expected %0d, actual %0d", name, exp, got);
    end
  endtask

  ////////////////////////////////////////
  // Stream driver and slave model
  ////////////////////////////////////////
  // Incrementing words with random gaps, held until taken
  always @(negedge aclk) begin
    if (!s_axis_tvalid || stream_took) begin
      stream_took   = 1'b0;
      s_axis_tvalid = 1'b0;
      if (!areset && stream_idx < stream_total && ($random(seed) & 3) != 0) begin
        s_axis_tvalid = 1'b1;
        s_axis_tdata  = WORD_BASE + 32'(stream_idx);
      end
    end
  end

  // Random ready, one response per burst with both address and data done
  always @(negedge aclk) begin
    m_axi_bvalid = 1'b0;
    if (!areset) begin
      m_axi_awready = ($random(seed) & 3) != 0;
      m_axi_wready  = ($random(seed) & 3) != 0;
      if (!hold_resp && resp_issued < aw_total && resp_issued < wlast_total) begin
        if (resp_wait == 0) begin
          m_axi_bvalid = 1'b1;
          resp_issued++;
          resp_wait = $random(seed) & 7;
        end else begin
          resp_wait--;
        end
      end
    end
  end

  // Compare process on every accepted transfer
  always @(posedge aclk) begin
    wm_pkg::aw_req_t exp_aw;
    wm_pkg::w_beat_t exp_w;
    if (!areset) begin
      // Words taken but not yet sent fill the FIFO
      check_ready(test_name, (stream_idx - beat_total) != FIFO_WORDS, s_axis_tready);
      if (s_axis_tvalid && s_axis_tready) begin
        stream_idx++;
        stream_took = 1'b1;
      end
      if (m_axi_awvalid && m_axi_awready) begin
        aw_total++;
        cmd_aw++;
        if (exp_aw_q.size() == 0) begin
          errors++;
          $display("ERROR %s: address accepted when none was expected", test_name);
        end else begin
          exp_aw = exp_aw_q.pop_front();
          check_aw(test_name, exp_aw, m_axi_aw);
        end
      end
      if (m_axi_wvalid && m_axi_wready) begin
        beat_total++;
        cmd_beats++;
        if (m_axi_w.last) begin
          wlast_total++;
        end
        if (exp_w_q.size() == 0) begin
          errors++;
          $display("ERROR %s: data beat accepted when none was expected", test_name);
        end else begin
          exp_w = exp_w_q.pop_front();
          check_w(test_name, exp_w, m_axi_w);
        end
      end
      if (m_axi_bvalid) begin
        cmd_resp++;
      end
      if (ctrl_done) begin
        done_count++;
        check_done(test_name, cmd_bursts, cmd_resp);
        if (exp_aw_q.size() != 0 || exp_w_q.size() != 0) begin
          errors++;
          $display("ERROR %s: done raised with %0d addresses and %0d beats still missing",
                   test_name, exp_aw_q.size(), exp_w_q.size());
        end
      end
    end
  end

  always @(posedge aclk) begin
    cycles++;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("ERROR timeout after %0d cycles in test %s", cycles, test_name);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  task automatic run_test(input string name, input logic [31:0] addr,
                          input logic [31:0] size, input bit hold);
    wm_pkg::xfer_cmd_t cmd;
    int                done_before;
    cmd.addr     = addr;
    cmd.size     = size;
    test_name    = name;
    cmd_bursts   = expected_transfer(cmd);
    cmd_resp     = 0;
    cmd_aw       = 0;
    cmd_beats    = 0;
    stream_total = exp_word;
    hold_resp    = hold;
    done_before  = done_count;
    @(negedge aclk);
    ctrl_cmd   = cmd;
    ctrl_start = 1'b1;
    @(negedge aclk);
    ctrl_start = 1'b0;
    if (hold) begin
      // Let data reach the sixth burst while no response returns
      while (cmd_beats <= 5 * 256) @(negedge aclk);
      repeat (20) @(negedge aclk);
      checks++;
      if (cmd_aw != MAX_OUT) begin
        errors++;
        $display("FAIL %s addresses with responses held: expected %0d, actual %0d",
                 name, MAX_OUT, cmd_aw);
      end
      hold_resp = 1'b0;
    end
    while (done_count == done_before) @(negedge aclk);
  endtask

  initial begin
    int total;
    areset        = 1'b1;
    ctrl_start    = 1'b0;
    ctrl_cmd      = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    m_axi_awready = 1'b0;
    m_axi_wready  = 1'b0;
    m_axi_bvalid  = 1'b0;
    total         = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total += int'((test_size[t] + 32'd3) >> 2);
    end
    cycle_limit = 8 * total + 2000;
    repeat (8) @(negedge aclk);
    areset = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(test_names[t], test_addr[t], test_size[t], t == NUM_TESTS - 1);
    end
    repeat (20) @(negedge aclk);
    check_done("all_commands", NUM_TESTS, done_count);
    $display("checks %0d, errors %0d, addresses %0d, beats %0d, done pulses %0d",
             checks, errors, aw_total, beat_total, done_count);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
rtl/wm_pkg.sv
rtl/xfer_setup.sv
rtl/stream_fifo.sv
rtl/wdata_channel.sv
rtl/waddr_channel.sv
rtl/wresp_tracker.sv
rtl/axi_write_master.sv
tb/axi_write_master_assertions.sv
tb/tb_axi_write_master.sv

/* run.sh */
#!/bin/sh
# Build and run the AXI write master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_write_master -f tb.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
